// ==== src.f ====
rtl/frame_fifo_pkg.sv
rtl/frame_write_ctrl.sv
rtl/frame_fifo_ram.sv
rtl/frame_read_pipe.sv
rtl/frame_pause_gate.sv
rtl/axis_frame_fifo.sv
test/frame_fifo_sva.sv
test/frame_fifo_tb.sv

// ==== test/frame_fifo_tb.sv ====
// directed testbench for the stream frame FIFO; top module frame_fifo_tb, compiled from src.f
module frame_fifo_tb
    import frame_fifo_pkg::*;
();

    localparam int DRIVE_DELAY = 10;
    localparam int WAIT_LIMIT = 300;
    localparam logic [7:0] LFSR_SEED = 8'd39;

    // conditions polled by wait_for
    localparam int W_DRAINED = 0;
    localparam int W_ACK = 1;
    localparam int W_XFER = 2;
    localparam int W_FULL = 3;

    logic   m_clk = 1'b0;
    logic   m_rst;
    data_t  in_data;
    logic   in_last;
    user_t  in_user;
    logic   in_valid;
    logic   in_ready;
    data_t  out_data;
    logic   out_last;
    user_t  out_user;
    logic   out_valid;
    logic   out_ready;
    logic   pause_req;
    logic   pause_ack;
    depth_t status_depth;
    depth_t status_depth_commit;
    logic   status_overflow;
    logic   status_bad_frame;
    logic   status_good_frame;

    logic [7:0] lfsr_state = LFSR_SEED;
    data_t      exp_data [$];
    logic       exp_last [$];
    user_t      exp_user [$];
    int         exp_good = 0;
    int         exp_bad = 0;
    int         exp_ovf = 0;
    int         good_cnt = 0;
    int         bad_cnt = 0;
    int         ovf_cnt = 0;

    always #50 m_clk = ~m_clk;

    axis_frame_fifo axis_frame_fifo_inst (.*);

    task automatic report_error(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic give_up(input string what);
        $display("timed out at time %0t waiting for %s", $time, what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped on wait timeout");
    endtask

    // 8-bit Fibonacci LFSR with taps 8 6 5 4 stepped once per data bit
    function automatic data_t next_byte();
        data_t b;
        b = '0;
        for (int i = 0; i < DATA_W; i++) begin
            lfsr_state = {lfsr_state[6:0],
                          lfsr_state[7] ^ lfsr_state[5] ^ lfsr_state[4] ^ lfsr_state[3]};
            b = {b[DATA_W-2:0], lfsr_state[0]};
        end
        return b;
    endfunction

    function automatic logic cond_met(input int kind);
        case (kind)
            W_DRAINED: return exp_data.size() == 0 && status_depth == 0
                              && status_depth_commit == 0;
            W_ACK: return pause_ack;
            W_XFER: return out_valid && out_ready;
            default: return status_depth_commit == DEPTH;
        endcase
    endfunction

    // polls at the falling edge where outputs and driven inputs are settled
    task automatic wait_for(input int kind, input string what);
        int waited;
        waited = 0;
        @(negedge m_clk);
        while (!cond_met(kind)) begin
            waited++;
            if (waited > WAIT_LIMIT) give_up(what);
            @(negedge m_clk);
        end
    endtask

    task automatic next_slot();
        @(posedge m_clk);
        #DRIVE_DELAY;
    endtask

    // drives one frame and updates the model by the frame outcome rules
    task automatic send_frame(input int len, input logic bad, input logic keep_ready);
        data_t d;
        int    waited;
        for (int i = 0; i < len; i++) begin
            d = next_byte();
            in_data = d;
            in_last = (i == len - 1);
            // inner beats carry a varying user value, only the last beat marks a bad frame
            in_user = (i == len - 1) ? user_t'(bad) : user_t'(i[0]);
            in_valid = 1'b1;
            if (!bad && len <= DEPTH) begin
                exp_data.push_back(d);
                exp_last.push_back(i == len - 1);
                exp_user.push_back(in_user);
            end
            waited = 0;
            @(negedge m_clk);
            while (!in_ready) begin
                assert (!keep_ready) else report_error("in_ready low during oversize frame");
                waited++;
                if (waited > WAIT_LIMIT) give_up("in_ready");
                @(negedge m_clk);
            end
            next_slot();
        end
        in_valid = 1'b0;
        in_last = 1'b0;
        if (len > DEPTH) exp_ovf++;
        else if (bad) exp_bad++;
        else exp_good++;
    endtask

    task automatic check_status();
        assert (good_cnt == exp_good && bad_cnt == exp_bad && ovf_cnt == exp_ovf)
            else report_error($sformatf("pulses good/bad/ovf %0d/%0d/%0d, expected %0d/%0d/%0d",
                                        good_cnt, bad_cnt, ovf_cnt, exp_good, exp_bad, exp_ovf));
    endtask

    // output scoreboard and status pulse counters
    always @(negedge m_clk) begin
        if (!m_rst) begin
            assert (axis_frame_fifo_inst.frame_fifo_sva_inst.fail_count == 0)
                else report_error("a bound protocol assertion failed");
            assert (!(pause_ack && out_valid)) else report_error("out_valid high during pause_ack");
            good_cnt += status_good_frame;
            bad_cnt += status_bad_frame;
            ovf_cnt += status_overflow;
            if (out_valid && out_ready) begin
                assert (exp_data.size() > 0) else report_error("output beat with no frame expected");
                assert (out_data == exp_data[0] && out_last == exp_last[0]
                        && out_user == exp_user[0])
                    else report_error($sformatf(
                        "beat %h last %b user %b, expected %h last %b user %b",
                        out_data, out_last, out_user, exp_data[0], exp_last[0], exp_user[0]));
                exp_data.delete(0);
                exp_last.delete(0);
                exp_user.delete(0);
            end
        end
    end

    task automatic good_frames_in_order();
        assert (in_ready && !out_valid && status_depth == 0 && status_depth_commit == 0)
            else report_error("FIFO not idle and empty after reset");
        send_frame(1, 1'b0, 1'b0);
        send_frame(5, 1'b0, 1'b0);
        send_frame(16, 1'b0, 1'b0);
        wait_for(W_DRAINED, "good frames to drain");
        check_status();
        next_slot();
    endtask

    task automatic bad_and_oversize_dropped();
        send_frame(6, 1'b1, 1'b0);
        send_frame(4, 1'b0, 1'b0);
        wait_for(W_DRAINED, "frame after the bad frame");
        check_status();
        next_slot();
        send_frame(20, 1'b0, 1'b1);
        send_frame(7, 1'b0, 1'b0);
        wait_for(W_DRAINED, "frame after the oversize frame");
        check_status();
        next_slot();
    endtask

    task automatic backpressure_fill_drain();
        out_ready = 1'b0;
        send_frame(10, 1'b0, 1'b0);
        send_frame(6, 1'b0, 1'b0);
        wait_for(W_FULL, "committed depth to reach capacity");
        assert (!in_ready && status_depth == DEPTH && exp_data.size() == DEPTH)
            else report_error($sformatf("full FIFO shows in_ready %b depth %0d",
                                        in_ready, status_depth));
        next_slot();
        out_ready = 1'b1;
        wait_for(W_DRAINED, "full FIFO to drain");
        check_status();
        next_slot();
    endtask

    task automatic pause_between_frames();
        pause_req = 1'b1;
        wait_for(W_ACK, "pause_ack while idle");
        next_slot();
        send_frame(5, 1'b0, 1'b0);
        // give the paused frame time to reach the output stage
        repeat (10) @(negedge m_clk);
        assert (pause_ack && exp_data.size() == 5) else report_error("frame left while paused");
        next_slot();
        pause_req = 1'b0;
        @(negedge m_clk);
        assert (pause_ack) else report_error("pause_ack fell before the next clock edge");
        @(negedge m_clk);
        assert (!pause_ack) else report_error("pause_ack high a cycle after pause_req fell");
        wait_for(W_DRAINED, "paused frame to drain");
        next_slot();
        send_frame(12, 1'b0, 1'b0);
        wait_for(W_XFER, "first beat of the frame");
        next_slot();
        // request arrives while the frame is still leaving
        pause_req = 1'b1;
        wait_for(W_ACK, "pause_ack after the frame");
        assert (exp_data.size() == 0) else report_error("pause cut the frame short");
        next_slot();
        pause_req = 1'b0;
        wait_for(W_DRAINED, "FIFO empty after pause");
        check_status();
    endtask

    initial begin
        m_rst = 1'b1;
        in_data = '0;
        in_last = 1'b0;
        in_user = '0;
        in_valid = 1'b0;
        out_ready = 1'b1;
        pause_req = 1'b0;
        repeat (8) @(posedge m_clk);
        #DRIVE_DELAY;
        m_rst = 1'b0;
        good_frames_in_order();
        bad_and_oversize_dropped();
        backpressure_fill_drain();
        pause_between_frames();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== test/frame_fifo_sva.sv ====
// protocol checker bound into axis_frame_fifo for the output stream, pause and status outputs
module frame_fifo_sva
    import frame_fifo_pkg::*;
(
    input logic   m_clk,
    input logic   m_rst,
    input data_t  out_data,
    input logic   out_last,
    input logic   out_valid,
    input logic   out_ready,
    input logic   pause_ack,
    input depth_t status_depth,
    input depth_t status_depth_commit,
    input logic   status_overflow,
    input logic   status_bad_frame,
    input logic   status_good_frame
);

    // number of failed properties so far
    int fail_count = 0;

    // a stalled beat stays on the bus unchanged
    assert property (@(posedge m_clk) disable iff (m_rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
        else begin
            $error("output beat changed or vanished while stalled");
            fail_count++;
        end

    assert property (@(posedge m_clk) disable iff (m_rst) pause_ack |-> !out_valid)
        else begin
            $error("out_valid high while pause_ack is high");
            fail_count++;
        end

    // each frame ends in exactly one outcome
    assert property (@(posedge m_clk) disable iff (m_rst)
        $onehot0({status_overflow, status_bad_frame, status_good_frame}))
        else begin
            $error("more than one status pulse in a cycle");
            fail_count++;
        end

    assert property (@(posedge m_clk) disable iff (m_rst)
        status_depth <= DEPTH && status_depth_commit <= DEPTH)
        else begin
            $error("status depth above FIFO capacity");
            fail_count++;
        end

endmodule

bind axis_frame_fifo frame_fifo_sva frame_fifo_sva_inst (.*);

// ==== rtl/axis_frame_fifo.sv ====
// top level of the single-clock stream frame FIFO; connects writer, storage, read pipeline and pause gate
module axis_frame_fifo
    import frame_fifo_pkg::*;
(
    input  logic   m_clk,
    input  logic   m_rst,

    input  data_t  in_data,
    input  logic   in_last,
    input  user_t  in_user,
    input  logic   in_valid,
    output logic   in_ready,

    output data_t  out_data,
    output logic   out_last,
    output user_t  out_user,
    output logic   out_valid,
    input  logic   out_ready,

    input  logic   pause_req,
    output logic   pause_ack,

    output depth_t status_depth,
    output depth_t status_depth_commit,
    output logic   status_overflow,
    output logic   status_bad_frame,
    output logic   status_good_frame
);

    ptr_t  rd_ptr;
    ptr_t  commit_ptr;
    logic  wr_en;
    ptr_t  wr_addr;
    word_t wr_word;
    ptr_t  rd_addr;
    word_t rd_word;
    data_t pipe_data;
    logic  pipe_last;
    user_t pipe_user;
    logic  pipe_valid;
    logic  pipe_ready;

    frame_write_ctrl frame_write_ctrl_inst (
        .m_clk(m_clk),
        .m_rst(m_rst),
        .in_data(in_data),
        .in_last(in_last),
        .in_user(in_user),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .rd_ptr(rd_ptr),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_word(wr_word),
        .commit_ptr(commit_ptr),
        .status_depth(status_depth),
        .status_depth_commit(status_depth_commit),
        .status_overflow(status_overflow),
        .status_bad_frame(status_bad_frame),
        .status_good_frame(status_good_frame)
    );

    frame_fifo_ram frame_fifo_ram_inst (
        .m_clk(m_clk),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_word(wr_word),
        .rd_addr(rd_addr),
        .rd_word(rd_word)
    );

    frame_read_pipe frame_read_pipe_inst (
        .m_clk(m_clk),
        .m_rst(m_rst),
        .commit_ptr(commit_ptr),
        .rd_ptr(rd_ptr),
        .rd_addr(rd_addr),
        .rd_word(rd_word),
        .pipe_data(pipe_data),
        .pipe_last(pipe_last),
        .pipe_user(pipe_user),
        .pipe_valid(pipe_valid),
        .pipe_ready(pipe_ready)
    );

    frame_pause_gate frame_pause_gate_inst (
        .m_clk(m_clk),
        .m_rst(m_rst),
        .pipe_data(pipe_data),
        .pipe_last(pipe_last),
        .pipe_user(pipe_user),
        .pipe_valid(pipe_valid),
        .pipe_ready(pipe_ready),
        .out_data(out_data),
        .out_last(out_last),
        .out_user(out_user),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .pause_req(pause_req),
        .pause_ack(pause_ack)
    );

endmodule

// ==== rtl/frame_pause_gate.sv ====
// output stage of the frame FIFO that holds the stream between frames while a pause is requested
module frame_pause_gate
    import frame_fifo_pkg::*;
(
    input  logic  m_clk,
    input  logic  m_rst,

    input  data_t pipe_data,
    input  logic  pipe_last,
    input  user_t pipe_user,
    input  logic  pipe_valid,
    output logic  pipe_ready,

    output data_t out_data,
    output logic  out_last,
    output user_t out_user,
    output logic  out_valid,
    input  logic  out_ready,

    input  logic  pause_req,
    output logic  pause_ack
);

    pause_state_t state;
    logic         block;
    logic         last_xfer;

    // between frames a request wins before a new beat is shown
    assign block = (state == PAUSE_HELD) || (state == PAUSE_IDLE && pause_req);

    assign out_valid = pipe_valid && !block;
    assign pipe_ready = out_ready && !block;
    assign out_data = pipe_data;
    assign out_last = pipe_last;
    assign out_user = pipe_user;

    assign last_xfer = out_valid && out_ready && pipe_last;
    assign pause_ack = state == PAUSE_HELD;

    always_ff @(posedge m_clk) begin
        if (m_rst) begin
            state <= PAUSE_IDLE;
        end else begin
            case (state)
                PAUSE_IDLE: begin
                    if (pause_req) begin
                        state <= PAUSE_HELD;
                    end else if (out_valid && !last_xfer) begin
                        state <= PAUSE_IN_FRAME;
                    end
                end
                PAUSE_IN_FRAME: begin
                    // frame runs to its last beat regardless of requests
                    if (last_xfer) begin
                        state <= pause_req ? PAUSE_HELD : PAUSE_IDLE;
                    end
                end
                PAUSE_HELD: begin
                    if (!pause_req) begin
                        state <= PAUSE_IDLE;
                    end
                end
                default: state <= PAUSE_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/frame_read_pipe.sv ====
// read side of the frame FIFO: fetches committed words into a bubble-collapsing output pipeline
module frame_read_pipe
    import frame_fifo_pkg::*;
(
    input  logic  m_clk,
    input  logic  m_rst,

    input  ptr_t  commit_ptr,
    output ptr_t  rd_ptr,

    output ptr_t  rd_addr,
    input  word_t rd_word,

    output data_t pipe_data,
    output logic  pipe_last,
    output user_t pipe_user,
    output logic  pipe_valid,
    input  logic  pipe_ready
);

    logic [PIPE_STAGES-1:0] stage_valid;
    logic [PIPE_STAGES-1:0] stage_adv;
    word_t                  stage_word [PIPE_STAGES];
    word_t                  out_word;
    logic                   empty;
    logic                   fetch;

    // only committed frames are visible to the reader
    assign empty = rd_addr == commit_ptr;

    // a stage loads when the output moves or any stage at or after it holds a bubble
    always_comb begin
        for (int j = 0; j < PIPE_STAGES; j++) begin
            stage_adv[j] = pipe_ready;
            for (int k = j; k < PIPE_STAGES; k++) begin
                if (!stage_valid[k]) begin
                    stage_adv[j] = 1'b1;
                end
            end
        end
    end

    assign fetch = stage_adv[0] && !empty;

    // valid bits and pointers
    always_ff @(posedge m_clk) begin
        if (m_rst) begin
            stage_valid <= '0;
            rd_addr <= '0;
            rd_ptr <= '0;
        end else begin
            for (int j = 1; j < PIPE_STAGES; j++) begin
                if (stage_adv[j]) begin
                    stage_valid[j] <= stage_valid[j-1];
                end
            end
            if (stage_adv[0]) begin
                stage_valid[0] <= fetch;
            end

            if (fetch) begin
                rd_addr <= rd_addr + 1'b1;
            end

            // words in flight still count against the FIFO capacity
            // until they leave the pipeline
            if (pipe_valid && pipe_ready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // payload stages, stage 0 is the registered RAM output
    always_ff @(posedge m_clk) begin
        for (int j = 1; j < PIPE_STAGES; j++) begin
            if (stage_adv[j]) begin
                stage_word[j] <= stage_word[j-1];
            end
        end
        if (stage_adv[0]) begin
            stage_word[0] <= rd_word;
        end
    end

    assign out_word = stage_word[PIPE_STAGES-1];

    assign pipe_valid = stage_valid[PIPE_STAGES-1];
    assign pipe_data = out_word[DATA_W-1:0];
    assign pipe_last = out_word[LAST_BIT];
    assign pipe_user = out_word[USER_LSB +: USER_W];

endmodule

// ==== rtl/frame_fifo_ram.sv ====
// frame FIFO storage array with one synchronous write port and one asynchronous read port
module frame_fifo_ram
    import frame_fifo_pkg::*;
(
    input  logic  m_clk,

    input  logic  wr_en,
    input  ptr_t  wr_addr,
    input  word_t wr_word,

    input  ptr_t  rd_addr,
    output word_t rd_word
);

    // small enough for LUT RAM, the read pipe registers the output
    (* ram_style = "distributed" *)
    word_t mem [DEPTH];

    // wrap bit is not part of the address
    always_ff @(posedge m_clk) begin
        if (wr_en) begin
            mem[wr_addr[FIFO_AW-1:0]] <= wr_word;
        end
    end

    assign rd_word = mem[rd_addr[FIFO_AW-1:0]];

endmodule

// ==== rtl/frame_write_ctrl.sv ====
// write side of the frame FIFO: accepts beats, stores or drops them, commits frames and reports status
module frame_write_ctrl
    import frame_fifo_pkg::*;
(
    input  logic   m_clk,
    input  logic   m_rst,

    input  data_t  in_data,
    input  logic   in_last,
    input  user_t  in_user,
    input  logic   in_valid,
    output logic   in_ready,

    input  ptr_t   rd_ptr,

    output logic   wr_en,
    output ptr_t   wr_addr,
    output word_t  wr_word,
    output ptr_t   commit_ptr,

    output depth_t status_depth,
    output depth_t status_depth_commit,
    output logic   status_overflow,
    output logic   status_bad_frame,
    output logic   status_good_frame
);

    ptr_t      wr_ptr;
    ptr_t      wr_ptr_next;
    ptr_t      fill_all;
    ptr_t      fill_frame;
    wr_state_t wr_state;
    logic      full;
    logic      full_wr;
    logic      accept;
    logic      drop_beat;
    logic      bad_marker;

    // occupancy against the reader, and size of the frame in progress
    assign fill_all = wr_ptr - rd_ptr;
    assign fill_frame = wr_ptr - commit_ptr;

    assign full = fill_all == DEPTH;
    assign full_wr = fill_frame == DEPTH;

    // keep accepting an overrun frame so it can be drained to its last beat
    assign in_ready = !full || full_wr;
    assign accept = in_valid && in_ready;

    assign drop_beat = full_wr || (wr_state == WR_DROP);
    assign bad_marker = (in_user & USER_BAD_FRAME_MASK)
                        == (USER_BAD_FRAME_VALUE & USER_BAD_FRAME_MASK);

    assign wr_ptr_next = wr_ptr + 1'b1;

    // RAM write port
    assign wr_en = accept && !drop_beat;
    assign wr_addr = wr_ptr;
    assign wr_word = {in_user, in_last, in_data};

    always_ff @(posedge m_clk) begin
        // status outputs are single-cycle pulses
        status_overflow <= 1'b0;
        status_bad_frame <= 1'b0;
        status_good_frame <= 1'b0;

        if (m_rst) begin
            wr_ptr <= '0;
            commit_ptr <= '0;
            wr_state <= WR_PASS;
        end else if (accept) begin
            if (drop_beat) begin
                // frame larger than the FIFO, discard through the last beat
                wr_state <= WR_DROP;
                if (in_last) begin
                    wr_ptr <= commit_ptr;
                    wr_state <= WR_PASS;
                    status_overflow <= 1'b1;
                end
            end else if (in_last && bad_marker) begin
                // roll back the whole frame
                wr_ptr <= commit_ptr;
                status_bad_frame <= 1'b1;
            end else if (in_last) begin
                // frame complete, make it visible to the reader
                wr_ptr <= wr_ptr_next;
                commit_ptr <= wr_ptr_next;
                status_good_frame <= 1'b1;
            end else begin
                wr_ptr <= wr_ptr_next;
            end
        end
    end

    // depth status, one cycle behind the pointers
    always_ff @(posedge m_clk) begin
        if (m_rst) begin
            status_depth <= '0;
            status_depth_commit <= '0;
        end else begin
            status_depth <= wr_ptr - rd_ptr;
            status_depth_commit <= commit_ptr - rd_ptr;
        end
    end

endmodule

// ==== rtl/frame_fifo_pkg.sv ====
// shared widths, depths, bad-frame marker and types for the frame FIFO; import with frame_fifo_pkg::*
package frame_fifo_pkg;

    // stream and storage sizing
    localparam int DATA_W = 8;
    localparam int USER_W = 1;
    localparam int FIFO_AW = 4;
    localparam int DEPTH = 2 ** FIFO_AW;

    // RAM output register plus this many further stages
    localparam int RAM_PIPELINE = 2;
    localparam int PIPE_STAGES = RAM_PIPELINE + 1;

    // stored word layout, data in the low bits, then last, then user
    localparam int WORD_W = DATA_W + 1 + USER_W;
    localparam int LAST_BIT = DATA_W;
    localparam int USER_LSB = DATA_W + 1;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [USER_W-1:0] user_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [FIFO_AW:0] ptr_t;
    typedef logic [FIFO_AW:0] depth_t;

    // a last beat whose masked user equals this value marks a bad frame
    localparam user_t USER_BAD_FRAME_VALUE = 1'b1;
    localparam user_t USER_BAD_FRAME_MASK = 1'b1;

    typedef enum logic {
        WR_PASS,
        WR_DROP
    } wr_state_t;

    typedef enum logic [1:0] {
        PAUSE_IDLE,
        PAUSE_IN_FRAME,
        PAUSE_HELD
    } pause_state_t;

endpackage
